//--- hw/timer_pkg.sv
package timer_pkg;

    // twelve time pulses make up one memory cycle
    localparam int NUM_TIME_PULSES = 12;

    // index of the current time pulse
    // only 1 .. 12 are legal, 0 and 13 .. 15 never appear
    typedef logic [3:0] time_pulse_t;

    // one bit per time pulse, bit 0 is T01 and bit 11 is T12
    typedef logic [NUM_TIME_PULSES-1:0] t_pulse_vec_t;

    // first pulse of the cycle
    localparam time_pulse_t T_FIRST = 4'd1;

    // last pulse, also the parking slot for restart and stop
    localparam time_pulse_t T_LAST = 4'd12;

    // clocks per time-pulse step
    // must be even and at least 4 so that rt, wt and ct fall in distinct phases
    localparam int DEFAULT_PHASES = 4;

endpackage

//--- hw/phase_if.sv
interface phase_if;

    // read strobe, first phase of each step
    logic rt;
    // write strobe, middle of each step
    logic wt;
    // clear strobe, last phase of each step
    logic ct;
    // advance request for the time-pulse sequence, same phase as ct
    logic step;

    // the divider drives every strobe
    modport gen (output rt, output wt, output ct, output step);
    // the sequencer only moves on step
    modport seq (input step);
    // restart and stop are evaluated on step
    modport ctl (input step);

endinterface

//--- hw/phase_generator.sv
module phase_generator #(
    parameter int PHASES = 4
) (
    input  logic clock,
    input  logic rst_n,
    input  logic wl15,
    input  logic wl16,
    phase_if.gen phases,
    output logic ovf,
    output logic unf
);

    // wide enough for 0 .. PHASES-1
    localparam int CW = $clog2(PHASES);

    // last counter value, the counter wraps to 0 after it
    localparam logic [CW-1:0] LAST_PHASE = CW'(PHASES - 1);
    // strobes are registered, so each one is loaded in the phase before it shows
    localparam logic [CW-1:0] WT_LOAD = CW'(PHASES / 2 - 1);
    localparam logic [CW-1:0] CT_LOAD = CW'(PHASES - 2);

    // sub-phase counter
    logic [CW-1:0] phase_cnt;

    // registered strobes
    logic rt_q;
    logic wt_q;
    logic ct_q;

    // an odd count or a count below 4 would merge two strobes
    if (PHASES < 4 || (PHASES % 2) != 0) begin : g_bad_phases
        $error("phase_generator: PHASES must be even and at least 4");
    end

    // free-running divider, 0 .. PHASES-1
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            phase_cnt <= '0;
        end else if (phase_cnt == LAST_PHASE) begin
            phase_cnt <= '0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    // decode one clock early so each strobe is high while the counter sits in its phase
    // rt in phase 0, wt in phase PHASES/2, ct in phase PHASES-1
    // all strobes low out of reset until their phase comes round
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rt_q <= 1'b0;
            wt_q <= 1'b0;
            ct_q <= 1'b0;
        end else begin
            // loading on the last phase puts rt in phase 0 after the wrap
            rt_q <= (phase_cnt == LAST_PHASE);
            wt_q <= (phase_cnt == WT_LOAD);
            ct_q <= (phase_cnt == CT_LOAD);
        end
    end

    assign phases.rt = rt_q;
    assign phases.wt = wt_q;
    assign phases.ct = ct_q;
    // step ends the time pulse together with the clear strobe
    assign phases.step = ct_q;

    // word-line sign check, only looked at on the clear strobe
    // overflow is 01 on wl16/wl15, underflow is 10
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ovf <= 1'b0;
            unf <= 1'b0;
        end else if (ct_q) begin
            ovf <= wl15 & ~wl16;
            unf <= wl16 & ~wl15;
        end
    end

endmodule

//--- hw/time_pulse_sequencer.sv
module time_pulse_sequencer (
    input  logic                    clock,
    input  logic                    rst_n,
    phase_if.seq                    phases,
    input  logic                    gojam,
    input  logic                    stop,
    output timer_pkg::time_pulse_t  time_pulse,
    output timer_pkg::t_pulse_vec_t t_pulse
);

    import timer_pkg::*;

    // index the sequence moves to on the next accepted step
    time_pulse_t next_pulse;

    // step that is not blocked by a manual stop
    logic advance;

    assign advance = phases.step & ~stop;

    // T12 wraps round to T01
    always_comb begin
        if (time_pulse == T_LAST) begin
            next_pulse = T_FIRST;
        end else begin
            next_pulse = time_pulse_t'(time_pulse + 4'd1);
        end
    end

    // comes out of reset parked at T12 so the first step lands on T01
    // gojam beats everything and holds the sequence at T12
    // a stop simply swallows the steps
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            time_pulse <= T_LAST;
        end else if (gojam) begin
            time_pulse <= T_LAST;
        end else if (advance) begin
            time_pulse <= next_pulse;
        end
    end

    // one-hot view of the registered index
    // bit i is pulse i+1, so T01 sits in bit 0
    always_comb begin
        t_pulse = '0;
        for (int i = 0; i < NUM_TIME_PULSES; i++) begin
            t_pulse[i] = (time_pulse == time_pulse_t'(i + 1));
        end
    end

endmodule

//--- hw/restart_control.sv
module restart_control (
    input  logic                   clock,
    input  logic                   rst_n,
    phase_if.ctl                   phases,
    // standby request
    input  logic                   sby,
    // alarm restart
    input  logic                   alga,
    // manual start from the panel
    input  logic                   mstrtp,
    // start requests from the test equipment
    input  logic                   strt1,
    input  logic                   strt2,
    // manual stop from the panel
    input  logic                   mstp,
    input  timer_pkg::time_pulse_t time_pulse,
    output logic                   gojam,
    output logic                   stop
);

    import timer_pkg::*;

    // any restart source asks for a go
    logic go_req;

    // step taken at the end of T12, the only point where the cycle may restart or halt
    logic t12_step;

    assign go_req = sby | alga | mstrtp | strt1 | strt2;

    assign t12_step = phases.step & (time_pulse == T_LAST);

    // restart pulse
    // set straight away by any request, and held while the request stays up
    // cleared only at a T12 boundary once every request has gone
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            gojam <= 1'b0;
        end else if (go_req) begin
            gojam <= 1'b1;
        end else if (t12_step) begin
            gojam <= 1'b0;
        end
    end

    // manual stop latch
    // engages only on the step that closes T12, never during a restart
    // releases on the first step that sees mstp low, at any pulse
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            stop <= 1'b0;
        end else if (phases.step) begin
            if (!mstp) begin
                stop <= 1'b0;
            end else if (t12_step && !gojam) begin
                stop <= 1'b1;
            end
        end
    end

endmodule

//--- hw/timer_top.sv
module timer_top #(
    parameter int PHASES = timer_pkg::DEFAULT_PHASES
) (
    // master clock
    input  logic                    clock,
    input  logic                    rst_n,
    // restart sources
    input  logic                    sby,
    input  logic                    alga,
    input  logic                    mstrtp,
    input  logic                    strt1,
    input  logic                    strt2,
    // manual stop
    input  logic                    mstp,
    // top two word-line bits, checked on the clear strobe
    input  logic                    wl15,
    input  logic                    wl16,
    // per-step phase strobes
    output logic                    rt,
    output logic                    wt,
    output logic                    ct,
    // one-hot time pulses T01 .. T12
    output timer_pkg::t_pulse_vec_t t_pulse,
    // restart and stop state
    output logic                    gojam,
    output logic                    stop,
    // word-line overflow and underflow flags
    output logic                    ovf,
    output logic                    unf
);

    import timer_pkg::*;

    // current time-pulse index, from the sequencer to the stop/restart logic
    time_pulse_t time_pulse;

    // phase strobes shared by all three blocks
    phase_if phases ();

    // clock divider with the overflow/underflow flags
    phase_generator #(
        .PHASES(PHASES)
    ) i_phase_generator (
        .clock (clock),
        .rst_n (rst_n),
        .wl15  (wl15),
        .wl16  (wl16),
        .phases(phases),
        .ovf   (ovf),
        .unf   (unf)
    );

    // T01 .. T12 stepping
    time_pulse_sequencer i_time_pulse_sequencer (
        .clock     (clock),
        .rst_n     (rst_n),
        .phases    (phases),
        .gojam     (gojam),
        .stop      (stop),
        .time_pulse(time_pulse),
        .t_pulse   (t_pulse)
    );

    // gojam and manual stop
    restart_control i_restart_control (
        .clock     (clock),
        .rst_n     (rst_n),
        .phases    (phases),
        .sby       (sby),
        .alga      (alga),
        .mstrtp    (mstrtp),
        .strt1     (strt1),
        .strt2     (strt2),
        .mstp      (mstp),
        .time_pulse(time_pulse),
        .gojam     (gojam),
        .stop      (stop)
    );

    // the memory side only needs rt, wt and ct
    // step stays inside the timer
    assign rt = phases.rt;
    assign wt = phases.wt;
    assign ct = phases.ct;

endmodule

//--- verif/timer_sva.sv
module timer_sva (
    input logic                    clock,
    input logic                    rst_n,
    input logic                    sby,
    input logic                    alga,
    input logic                    mstrtp,
    input logic                    strt1,
    input logic                    strt2,
    input logic                    mstp,
    input logic                    wl15,
    input logic                    wl16,
    input logic                    rt,
    input logic                    wt,
    input logic                    ct,
    input timer_pkg::t_pulse_vec_t t_pulse,
    input logic                    gojam,
    input logic                    stop,
    input logic                    ovf,
    input logic                    unf
);

    import timer_pkg::*;

    // parking slot, top bit of the one-hot vector
    localparam t_pulse_vec_t T12_VEC = t_pulse_vec_t'(1) << (NUM_TIME_PULSES - 1);

    // failed assertions so far, watched by the testbench
    int fail_count = 0;

    // any of the five restart sources
    logic go_any;
    // expected values for the clock after a clear strobe
    t_pulse_vec_t rot_q;
    logic ovf_q;
    logic unf_q;

    assign go_any = sby | alga | mstrtp | strt1 | strt2;

    always_ff @(posedge clock) begin
        // each pulse hands over to the next slot up, T12 back to T01
        rot_q <= {t_pulse[NUM_TIME_PULSES-2:0], t_pulse[NUM_TIME_PULSES-1]};
        // overflow is wl15 alone, underflow is wl16 alone
        ovf_q <= wl15 && !wl16;
        unf_q <= wl16 && !wl15;
    end

    // out of reset everything is quiet and the sequence sits at T12
    a_reset: assert property (@(posedge clock) $rose(rst_n) |-> t_pulse == T12_VEC
        && !gojam && !stop && !ovf && !unf && !rt && !wt && !ct)
        else begin
            $error("outputs were not at their reset values when reset was released");
            fail_count++;
        end

    // rt, quiet, wt, ct, then rt again
    a_strobe_seq: assert property (@(posedge clock) disable iff (!rst_n)
        rt |=> (!rt && !wt && !ct) ##1 (wt && !rt && !ct) ##1 (ct && !rt && !wt) ##1 rt)
        else begin
            $error("phase strobes did not follow rt in the expected order");
            fail_count++;
        end

    a_rt_live: assert property (@(posedge clock) disable iff (!rst_n) !rt [*4] |=> rt)
        else begin
            $error("rt stayed low for more than one step");
            fail_count++;
        end

    a_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot(t_pulse))
        else begin
            $error("Mismatch onehot: expected one bit set, actual %h", $sampled(t_pulse));
            fail_count++;
        end

    a_rotate: assert property (@(posedge clock) disable iff (!rst_n)
        (ct && !gojam && !stop) |=> t_pulse == rot_q)
        else begin
            $error("Mismatch rotate: expected %h, actual %h", $sampled(rot_q), $sampled(t_pulse));
            fail_count++;
        end

    // no step, or a stop in force, leaves the sequence where it is
    a_hold: assert property (@(posedge clock) disable iff (!rst_n)
        (!gojam && (!ct || stop)) |=> $stable(t_pulse))
        else begin
            $error("t_pulse moved without an accepted step");
            fail_count++;
        end

    a_gojam_rise: assert property (@(posedge clock) disable iff (!rst_n) go_any |=> gojam)
        else begin
            $error("gojam did not rise after a restart request");
            fail_count++;
        end

    a_gojam_park: assert property (@(posedge clock) disable iff (!rst_n)
        gojam |=> t_pulse == T12_VEC)
        else begin
            $error("Mismatch park: expected %h, actual %h", T12_VEC, $sampled(t_pulse));
            fail_count++;
        end

    a_gojam_clear: assert property (@(posedge clock) disable iff (!rst_n)
        (gojam && ct && t_pulse == T12_VEC && !go_any) |=> !gojam)
        else begin
            $error("gojam stayed high after a T12 step with no restart request");
            fail_count++;
        end

    a_gojam_fall: assert property (@(posedge clock) disable iff (!rst_n)
        $fell(gojam) |-> $past(ct && t_pulse == T12_VEC && !go_any))
        else begin
            $error("gojam fell away from a T12 step");
            fail_count++;
        end

    a_stop_set: assert property (@(posedge clock) disable iff (!rst_n)
        (ct && t_pulse == T12_VEC && !gojam && mstp) |=> stop)
        else begin
            $error("stop did not rise after the T12 step with mstp high");
            fail_count++;
        end

    a_stop_cause: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(stop) |-> $past(ct && t_pulse == T12_VEC && !gojam && mstp))
        else begin
            $error("stop rose without a T12 step and mstp");
            fail_count++;
        end

    a_stop_clear: assert property (@(posedge clock) disable iff (!rst_n)
        (ct && !mstp) |=> !stop)
        else begin
            $error("stop stayed high after a step with mstp low");
            fail_count++;
        end

    a_flags: assert property (@(posedge clock) disable iff (!rst_n)
        ct |=> (ovf == ovf_q && unf == unf_q))
        else begin
            $error("Mismatch flags: expected ovf %b unf %b, actual ovf %b unf %b",
                $sampled(ovf_q), $sampled(unf_q), $sampled(ovf), $sampled(unf));
            fail_count++;
        end

    a_flags_hold: assert property (@(posedge clock) disable iff (!rst_n)
        !ct |=> ($stable(ovf) && $stable(unf)))
        else begin
            $error("ovf or unf changed away from a clear strobe");
            fail_count++;
        end

endmodule

bind timer_top timer_sva i_timer_sva (.*);

//--- verif/timer_tb.sv
module timer_tb;

    import timer_pkg::*;

    localparam int PHASES = 4;
    // one memory cycle is twelve steps
    localparam int CYCLE_CLOCKS = NUM_TIME_PULSES * PHASES;
    // the sequence below needs about six memory cycles
    localparam int TIMEOUT_CLOCKS = 10 * CYCLE_CLOCKS;

    logic         clock;
    logic         rst_n;
    logic         sby;
    logic         alga;
    logic         mstrtp;
    logic         strt1;
    logic         strt2;
    logic         mstp;
    logic         wl15;
    logic         wl16;
    logic         rt;
    logic         wt;
    logic         ct;
    t_pulse_vec_t t_pulse;
    logic         gojam;
    logic         stop;
    logic         ovf;
    logic         unf;

    // word-line stimulus
    integer      seed = 32'h4240722b;
    logic [31:0] rnd;

    int cycle_count = 0;

    timer_top #(
        .PHASES(PHASES)
    ) i_timer_top (
        .clock  (clock),
        .rst_n  (rst_n),
        .sby    (sby),
        .alga   (alga),
        .mstrtp (mstrtp),
        .strt1  (strt1),
        .strt2  (strt2),
        .mstp   (mstp),
        .wl15   (wl15),
        .wl16   (wl16),
        .rt     (rt),
        .wt     (wt),
        .ct     (ct),
        .t_pulse(t_pulse),
        .gojam  (gojam),
        .stop   (stop),
        .ovf    (ovf),
        .unf    (unf)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // fresh word-line bits every clock, just after the edge
    always @(posedge clock) begin
        #1;
        rnd = $random(seed);
        wl15 = rnd[0];
        wl16 = rnd[1];
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CLOCKS) begin
            $display("Simulation failed");
            $fatal(1, "timeout, the test sequence did not finish in %0d clocks", TIMEOUT_CLOCKS);
        end
    end

    // stop at the first assertion that fires
    always @(i_timer_top.i_timer_sva.fail_count) begin
        if (i_timer_top.i_timer_sva.fail_count != 0) begin
            $display("Simulation failed");
            $fatal(1, "the timer checker reported an assertion failure");
        end
    end

    // move to just after the next rising edge
    task automatic next_clock();
        @(posedge clock);
        #1;
    endtask

    // returns in the cycle of the n-th clear strobe from now
    task automatic wait_steps(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            next_clock();
            if (ct === 1'b1) begin
                seen++;
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        sby = 1'b0;
        alga = 1'b0;
        mstrtp = 1'b0;
        strt1 = 1'b0;
        strt2 = 1'b0;
        mstp = 1'b0;
        wl15 = 1'b0;
        wl16 = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // three free-running memory cycles
        wait_steps(3 * NUM_TIME_PULSES);

        // single-clock restart request
        next_clock();
        strt1 = 1'b1;
        next_clock();
        strt1 = 1'b0;
        // gojam holds until the next T12 step
        while (gojam !== 1'b0) begin
            next_clock();
        end
        wait_steps(NUM_TIME_PULSES);

        // manual stop, engages at the end of T12
        mstp = 1'b1;
        while (stop !== 1'b1) begin
            next_clock();
        end
        // frozen across two steps
        wait_steps(2);
        mstp = 1'b0;
        while (stop !== 1'b0) begin
            next_clock();
        end
        // a full cycle after the release
        wait_steps(NUM_TIME_PULSES + 1);

        repeat (2) next_clock();
        if (i_timer_top.i_timer_sva.fail_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "the timer checker reported an assertion failure");
        end
    end

endmodule

//--- sim.f
hw/timer_pkg.sv
hw/phase_if.sv
hw/phase_generator.sv
hw/time_pulse_sequencer.sv
hw/restart_control.sv
hw/timer_top.sv
verif/timer_sva.sv
verif/timer_tb.sv

//--- Bender.yml
package:
  name: timer

sources:
  - hw/timer_pkg.sv
  - hw/phase_if.sv
  - hw/phase_generator.sv
  - hw/time_pulse_sequencer.sv
  - hw/restart_control.sv
  - hw/timer_top.sv
  - target: simulation
    files:
      - verif/timer_sva.sv
      - verif/timer_tb.sv
